// File: verilog/isa_pkg.sv
package isa_pkg;

	localparam int INSTR_W = 16;
	localparam int DATA_W = 16;
	localparam int REG_N = 8;
	localparam int REG_AW = 3;

	// Link register, also written by JAL and JALR.
	localparam logic [REG_AW-1:0] LINK_REG = 3'd7;

	// Field positions in the instruction word.
	localparam int OPC_LSB = 11;
	localparam int OPC_W = 5;
	localparam int RS_LSB = 8;
	localparam int RT_LSB = 5;
	localparam int RD_LSB = 2;
	localparam int FUNC_LSB = 0;
	localparam int FUNC_W = 2;

	localparam int IMM5_W = 5;
	localparam int IMM8_W = 8;
	localparam int IMM11_W = 11;

	typedef enum logic [OPC_W-1:0] {
		OP_HALT = 5'b00000, OP_NOP = 5'b00001, OP_SIIC = 5'b00010, OP_RTI = 5'b00011,
		OP_J = 5'b00100, OP_JR = 5'b00101, OP_JAL = 5'b00110, OP_JALR = 5'b00111,
		OP_ADDI = 5'b01000, OP_SUBI = 5'b01001, OP_XORI = 5'b01010, OP_ANDNI = 5'b01011,
		OP_BEQZ = 5'b01100, OP_BNEZ = 5'b01101, OP_BLTZ = 5'b01110, OP_BGEZ = 5'b01111,
		OP_ST = 5'b10000, OP_LD = 5'b10001, OP_SLBI = 5'b10010, OP_STU = 5'b10011,
		OP_ROLI = 5'b10100, OP_SLLI = 5'b10101, OP_RORI = 5'b10110, OP_SRLI = 5'b10111,
		OP_LBI = 5'b11000, OP_BTR = 5'b11001,
		OP_ALU_SHIFT = 5'b11010, OP_ALU_ARITH = 5'b11011,
		OP_SEQ = 5'b11100, OP_SLT = 5'b11101, OP_SLE = 5'b11110, OP_SCO = 5'b11111
	} opcode_e;

endpackage

// File: verilog/ctrl_pkg.sv
package ctrl_pkg;

	// Low two bits of the first eight follow the ISA function field.
	typedef enum logic [3:0] {
		ALU_ADD = 4'd0, ALU_SUB = 4'd1, ALU_XOR = 4'd2, ALU_ANDN = 4'd3,
		ALU_ROL = 4'd4, ALU_SLL = 4'd5, ALU_ROR = 4'd6, ALU_SRL = 4'd7,
		ALU_SEQ = 4'd8, ALU_SLT = 4'd9, ALU_SLE = 4'd10, ALU_SCO = 4'd11,
		ALU_BTR = 4'd12, ALU_PASSB = 4'd13, ALU_SLBI = 4'd14
	} alu_op_e;

	// RD_RT is the rd field of the format, which sits in the rt slot for I-format.
	typedef enum logic [1:0] {RD_RT, RD_RS, R7} dst_sel_e;

	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wb_sel_e;

	typedef enum logic [2:0] {BR_NONE, BR_EQZ, BR_NEZ, BR_LTZ, BR_GEZ} br_cond_e;

	typedef struct packed {
		alu_op_e alu_op;
		logic alu_src_imm;
		logic sign_ext;
		dst_sel_e dst_sel;
		wb_sel_e wb_sel;
		logic reg_write;
		logic mem_read;
		logic mem_write;
		br_cond_e br_cond;
		logic jump;
		logic jump_reg;
	} ctrl_t;

	localparam ctrl_t CTRL_NOP = '{
		alu_op: ALU_ADD, alu_src_imm: 1'b0, sign_ext: 1'b0, dst_sel: RD_RT,
		wb_sel: WB_ALU, reg_write: 1'b0, mem_read: 1'b0, mem_write: 1'b0,
		br_cond: BR_NONE, jump: 1'b0, jump_reg: 1'b0
	};

endpackage

// File: verilog/ctrl_if.sv
`timescale 1ns/100ps

interface ctrl_if import isa_pkg::*, ctrl_pkg::*; ();

	logic valid;
	ctrl_t ctrl;
	logic [REG_AW-1:0] rs_idx;
	logic [REG_AW-1:0] rt_idx;
	logic [REG_AW-1:0] dst_idx;
	logic [DATA_W-1:0] imm;
	logic [DATA_W-1:0] pc;

	modport decode (output valid, ctrl, rs_idx, rt_idx, dst_idx, imm, pc);

	modport execute (input valid, ctrl, rs_idx, rt_idx, dst_idx, imm, pc);

endinterface

// File: verilog/exec_if.sv
`timescale 1ns/100ps

interface exec_if import isa_pkg::*; ();

	logic valid;
	logic reg_write;
	logic [REG_AW-1:0] dst_idx;
	logic [DATA_W-1:0] wr_data;
	logic redirect;
	logic [DATA_W-1:0] target;

	modport execute (output valid, reg_write, dst_idx, wr_data, redirect, target);

	modport result (input valid, reg_write, dst_idx, wr_data, redirect, target);

endinterface

// File: verilog/instr_decode.sv
`timescale 1ns/100ps

module instr_decode import isa_pkg::*, ctrl_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic instr_valid,
	input logic [INSTR_W-1:0] instr,
	input logic [DATA_W-1:0] instr_pc,
	ctrl_if.decode cq,
	output logic halt,
	output logic err
);

	opcode_e opcode;
	logic [FUNC_W-1:0] func;
	logic [FUNC_W-1:0] opc_func;
	ctrl_t ctrl;
	logic legal;
	logic is_halt;
	logic accept;
	logic ill_q;
	logic [3:0] imm_len;
	logic [DATA_W-1:0] imm_mask;
	logic [DATA_W-1:0] imm_ext;
	logic [REG_AW-1:0] rd_idx;
	logic [REG_AW-1:0] dst_idx;

	assign opcode = opcode_e'(instr[OPC_LSB +: OPC_W]);
	assign func = instr[FUNC_LSB +: FUNC_W];
	assign opc_func = instr[OPC_LSB +: FUNC_W];
	assign accept = instr_valid && !halt;

	always_comb begin
		ctrl = CTRL_NOP;
		legal = 1'b1;
		is_halt = 1'b0;
		imm_len = 4'(IMM5_W);
		rd_idx = instr[RT_LSB +: REG_AW];
		case (opcode)
			OP_HALT: begin
				is_halt = 1'b1;
			end
			OP_NOP, OP_SIIC, OP_RTI: begin
			end
			OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI: begin
				ctrl.alu_op = alu_op_e'({2'b00, opc_func});
				ctrl.alu_src_imm = 1'b1;
				// Only ADDI and SUBI sign extend.
				ctrl.sign_ext = ~opc_func[1];
				ctrl.reg_write = 1'b1;
			end
			OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI: begin
				ctrl.alu_op = alu_op_e'({2'b01, opc_func});
				ctrl.alu_src_imm = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			OP_ST, OP_LD, OP_STU: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.sign_ext = 1'b1;
				ctrl.mem_write = (opcode != OP_LD);
				ctrl.mem_read = (opcode == OP_LD);
				ctrl.reg_write = (opcode != OP_ST);
				ctrl.wb_sel = (opcode == OP_LD) ? WB_MEM : WB_ALU;
				ctrl.dst_sel = (opcode == OP_STU) ? RD_RS : RD_RT;
			end
			OP_LBI, OP_SLBI: begin
				ctrl.alu_op = (opcode == OP_LBI) ? ALU_PASSB : ALU_SLBI;
				ctrl.alu_src_imm = 1'b1;
				ctrl.sign_ext = (opcode == OP_LBI);
				ctrl.reg_write = 1'b1;
				ctrl.dst_sel = RD_RS;
				imm_len = 4'(IMM8_W);
			end
			OP_ALU_ARITH, OP_ALU_SHIFT: begin
				ctrl.alu_op = alu_op_e'({1'b0, opcode == OP_ALU_SHIFT, func});
				ctrl.reg_write = 1'b1;
				rd_idx = instr[RD_LSB +: REG_AW];
			end
			OP_BTR, OP_SEQ, OP_SLT, OP_SLE, OP_SCO: begin
				case (opcode)
					OP_BTR: ctrl.alu_op = ALU_BTR;
					OP_SEQ: ctrl.alu_op = ALU_SEQ;
					OP_SLT: ctrl.alu_op = ALU_SLT;
					OP_SLE: ctrl.alu_op = ALU_SLE;
					default: ctrl.alu_op = ALU_SCO;
				endcase
				ctrl.reg_write = 1'b1;
				rd_idx = instr[RD_LSB +: REG_AW];
				// Function bits are reserved here and must be zero.
				legal = (func == '0);
			end
			OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: begin
				case (opcode)
					OP_BEQZ: ctrl.br_cond = BR_EQZ;
					OP_BNEZ: ctrl.br_cond = BR_NEZ;
					OP_BLTZ: ctrl.br_cond = BR_LTZ;
					default: ctrl.br_cond = BR_GEZ;
				endcase
				ctrl.sign_ext = 1'b1;
				imm_len = 4'(IMM8_W);
			end
			OP_J, OP_JAL, OP_JR, OP_JALR: begin
				ctrl.jump = 1'b1;
				ctrl.sign_ext = 1'b1;
				ctrl.jump_reg = (opcode == OP_JR) || (opcode == OP_JALR);
				imm_len = ctrl.jump_reg ? 4'(IMM8_W) : 4'(IMM11_W);
				if (opcode == OP_JAL || opcode == OP_JALR) begin
					ctrl.reg_write = 1'b1;
					ctrl.wb_sel = WB_LINK;
					ctrl.dst_sel = R7;
				end
			end
			default: begin
				legal = 1'b0;
			end
		endcase
	end

	always_comb begin
		imm_mask = (DATA_W'(1) << imm_len) - DATA_W'(1);
		imm_ext = instr & imm_mask;
		if (ctrl.sign_ext && instr[imm_len - 4'd1]) begin
			imm_ext = imm_ext | ~imm_mask;
		end
	end

	always_comb begin
		case (ctrl.dst_sel)
			RD_RS: dst_idx = instr[RS_LSB +: REG_AW];
			R7: dst_idx = LINK_REG;
			default: dst_idx = rd_idx;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cq.valid <= 1'b0;
			halt <= 1'b0;
			ill_q <= 1'b0;
			err <= 1'b0;
		end else begin
			cq.valid <= accept && legal;
			halt <= halt || (accept && is_halt);
			// Err lines up with the write-back outputs.
			ill_q <= accept && !legal;
			err <= ill_q;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			cq.ctrl <= ctrl;
			cq.rs_idx <= instr[RS_LSB +: REG_AW];
			cq.rt_idx <= instr[RT_LSB +: REG_AW];
			cq.dst_idx <= dst_idx;
			cq.imm <= imm_ext;
			cq.pc <= instr_pc;
		end
	end

endmodule

// File: verilog/alu_execute.sv
`timescale 1ns/100ps

module alu_execute import isa_pkg::*, ctrl_pkg::*; (
	ctrl_if.execute cq,
	exec_if.execute eq,
	output logic [REG_AW-1:0] rs_idx,
	output logic [REG_AW-1:0] rt_idx,
	input logic [DATA_W-1:0] rs_data,
	input logic [DATA_W-1:0] rt_data,
	input logic [DATA_W-1:0] mem_rdata,
	output logic mem_en,
	output logic mem_we,
	output logic [DATA_W-1:0] mem_addr,
	output logic [DATA_W-1:0] mem_wdata
);

	logic [DATA_W-1:0] op_a;
	logic [DATA_W-1:0] op_b;
	logic [3:0] shamt;
	logic [DATA_W-1:0] sum;
	logic carry;
	logic [2*DATA_W-1:0] rot_l;
	logic [2*DATA_W-1:0] rot_r;
	logic [DATA_W-1:0] rev;
	logic [DATA_W-1:0] alu_res;
	logic [DATA_W-1:0] link_pc;
	logic [DATA_W-1:0] br_base;
	logic taken;

	assign rs_idx = cq.rs_idx;
	assign rt_idx = cq.rt_idx;

	assign op_a = rs_data;
	assign op_b = cq.ctrl.alu_src_imm ? cq.imm : rt_data;
	assign shamt = op_b[3:0];

	assign {carry, sum} = {1'b0, op_a} + {1'b0, op_b};
	assign rot_l = {op_a, op_a} << shamt;
	assign rot_r = {op_a, op_a} >> shamt;

	always_comb begin
		for (int i = 0; i < DATA_W; i++) begin
			rev[i] = op_a[DATA_W-1-i];
		end
	end

	always_comb begin
		case (cq.ctrl.alu_op)
			ALU_ADD: alu_res = sum;
			// Subtract takes A from B.
			ALU_SUB: alu_res = op_b - op_a;
			ALU_XOR: alu_res = op_a ^ op_b;
			ALU_ANDN: alu_res = op_a & ~op_b;
			ALU_ROL: alu_res = rot_l[2*DATA_W-1:DATA_W];
			ALU_SLL: alu_res = op_a << shamt;
			ALU_ROR: alu_res = rot_r[DATA_W-1:0];
			ALU_SRL: alu_res = op_a >> shamt;
			ALU_SEQ: alu_res = DATA_W'(op_a == op_b);
			ALU_SLT: alu_res = DATA_W'($signed(op_a) < $signed(op_b));
			ALU_SLE: alu_res = DATA_W'($signed(op_a) <= $signed(op_b));
			ALU_SCO: alu_res = DATA_W'(carry);
			ALU_BTR: alu_res = rev;
			ALU_PASSB: alu_res = op_b;
			ALU_SLBI: alu_res = (op_a << 8) | op_b;
			default: alu_res = sum;
		endcase
	end

	// Zero tests on rs.
	always_comb begin
		case (cq.ctrl.br_cond)
			BR_EQZ: taken = (op_a == '0);
			BR_NEZ: taken = (op_a != '0);
			BR_LTZ: taken = op_a[DATA_W-1];
			BR_GEZ: taken = !op_a[DATA_W-1];
			default: taken = 1'b0;
		endcase
	end

	assign link_pc = cq.pc + DATA_W'(2);
	assign br_base = cq.ctrl.jump_reg ? op_a : link_pc;

	assign mem_en = cq.valid && (cq.ctrl.mem_read || cq.ctrl.mem_write);
	assign mem_we = cq.valid && cq.ctrl.mem_write;
	assign mem_addr = sum;
	assign mem_wdata = rt_data;

	always_comb begin
		case (cq.ctrl.wb_sel)
			WB_MEM: eq.wr_data = mem_rdata;
			WB_LINK: eq.wr_data = link_pc;
			default: eq.wr_data = alu_res;
		endcase
	end

	assign eq.valid = cq.valid;
	assign eq.reg_write = cq.ctrl.reg_write;
	assign eq.dst_idx = cq.dst_idx;
	assign eq.redirect = taken || cq.ctrl.jump;
	assign eq.target = br_base + cq.imm;

endmodule

// File: verilog/result_stage.sv
`timescale 1ns/100ps

module result_stage import isa_pkg::*; (
	input logic clk,
	input logic rst_n,
	exec_if.result eq,
	input logic [REG_AW-1:0] rs_idx,
	input logic [REG_AW-1:0] rt_idx,
	output logic [DATA_W-1:0] rs_data,
	output logic [DATA_W-1:0] rt_data,
	output logic wb_valid,
	output logic [REG_AW-1:0] wb_reg,
	output logic [DATA_W-1:0] wb_data,
	output logic redirect,
	output logic [DATA_W-1:0] redirect_pc
);

	logic [DATA_W-1:0] regs [REG_N];
	logic do_write;

	assign do_write = eq.valid && eq.reg_write;

	// Register file comes out of reset as all zero.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < REG_N; i++) begin
				regs[i] <= '0;
			end
		end else if (do_write) begin
			regs[eq.dst_idx] <= eq.wr_data;
		end
	end

	assign rs_data = regs[rs_idx];
	assign rt_data = regs[rt_idx];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
			redirect <= 1'b0;
		end else begin
			wb_valid <= do_write;
			redirect <= eq.valid && eq.redirect;
		end
	end

	always_ff @(posedge clk) begin
		wb_reg <= eq.dst_idx;
		wb_data <= eq.wr_data;
		redirect_pc <= eq.target;
	end

endmodule

// File: verilog/core_slice_top.sv
`timescale 1ns/100ps

module core_slice_top import isa_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic instr_valid,
	input logic [INSTR_W-1:0] instr,
	input logic [DATA_W-1:0] instr_pc,
	input logic [DATA_W-1:0] mem_rdata,
	output logic mem_en,
	output logic mem_we,
	output logic [DATA_W-1:0] mem_addr,
	output logic [DATA_W-1:0] mem_wdata,
	output logic wb_valid,
	output logic [REG_AW-1:0] wb_reg,
	output logic [DATA_W-1:0] wb_data,
	output logic redirect,
	output logic [DATA_W-1:0] redirect_pc,
	output logic halt,
	output logic err
);

	logic [REG_AW-1:0] rs_idx;
	logic [REG_AW-1:0] rt_idx;
	logic [DATA_W-1:0] rs_data;
	logic [DATA_W-1:0] rt_data;

	ctrl_if u_ctrl_if ();
	exec_if u_exec_if ();

	instr_decode u_decode (
		.clk(clk),
		.rst_n(rst_n),
		.instr_valid(instr_valid),
		.instr(instr),
		.instr_pc(instr_pc),
		.cq(u_ctrl_if.decode),
		.halt(halt),
		.err(err)
	);

	alu_execute u_execute (
		.cq(u_ctrl_if.execute),
		.eq(u_exec_if.execute),
		.rs_idx(rs_idx),
		.rt_idx(rt_idx),
		.rs_data(rs_data),
		.rt_data(rt_data),
		.mem_rdata(mem_rdata),
		.mem_en(mem_en),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata)
	);

	result_stage u_result (
		.clk(clk),
		.rst_n(rst_n),
		.eq(u_exec_if.result),
		.rs_idx(rs_idx),
		.rt_idx(rt_idx),
		.rs_data(rs_data),
		.rt_data(rt_data),
		.wb_valid(wb_valid),
		.wb_reg(wb_reg),
		.wb_data(wb_data),
		.redirect(redirect),
		.redirect_pc(redirect_pc)
	);

endmodule

// File: bench/core_slice_checker.sv
`timescale 1ns/100ps

module core_slice_checker import isa_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic mem_en,
	input logic mem_we,
	input logic [DATA_W-1:0] mem_addr,
	input logic [DATA_W-1:0] mem_wdata,
	input logic wb_valid,
	input logic [REG_AW-1:0] wb_reg,
	input logic [DATA_W-1:0] wb_data,
	input logic redirect,
	input logic [DATA_W-1:0] redirect_pc,
	input logic halt,
	input logic err,
	input logic exp_mem_en,
	input logic exp_mem_we,
	input logic [DATA_W-1:0] exp_mem_addr,
	input logic [DATA_W-1:0] exp_mem_wdata,
	input logic exp_wb_valid,
	input logic [REG_AW-1:0] exp_wb_reg,
	input logic [DATA_W-1:0] exp_wb_data,
	input logic exp_redirect,
	input logic [DATA_W-1:0] exp_redirect_pc,
	input logic exp_halt,
	input logic exp_err
);

	int unsigned fail_count = 0;

	// Control outputs stay low while reset is held.
	a_reset_low: assert property (@(posedge clk)
		!rst_n |-> !(mem_en || mem_we || wb_valid || redirect || halt || err))
		else begin
			fail_count++;
			$error("FAILED at %0t: control output high during reset", $time);
		end

	// Memory request during the execute cycle.
	a_mem_req: assert property (@(posedge clk) disable iff (!rst_n)
		mem_en == exp_mem_en && mem_we == exp_mem_we
		&& (!exp_mem_en || mem_addr == exp_mem_addr)
		&& (!exp_mem_we || mem_wdata == exp_mem_wdata))
		else begin
			fail_count++;
			$error("FAILED at %0t: memory request mismatch", $time);
		end

	a_write_back: assert property (@(posedge clk) disable iff (!rst_n)
		wb_valid == exp_wb_valid
		&& (!exp_wb_valid || (wb_reg == exp_wb_reg && wb_data == exp_wb_data)))
		else begin
			fail_count++;
			$error("FAILED at %0t: write-back mismatch", $time);
		end

	a_redirect: assert property (@(posedge clk) disable iff (!rst_n)
		redirect == exp_redirect && (!exp_redirect || redirect_pc == exp_redirect_pc))
		else begin
			fail_count++;
			$error("FAILED at %0t: redirect mismatch", $time);
		end

	a_status: assert property (@(posedge clk) disable iff (!rst_n)
		halt == exp_halt && err == exp_err)
		else begin
			fail_count++;
			$error("FAILED at %0t: halt or err mismatch", $time);
		end

endmodule

// File: bench/tb_core_slice.sv
`timescale 1ns/100ps

module tb_core_slice import isa_pkg::*; ();

	localparam int CLK_PERIOD = 8;
	localparam int RST_CYCLES = 16;
	localparam int N_RAND = 300;
	localparam int N_TAIL = 14;

	typedef struct packed {
		logic mem_en;
		logic mem_we;
		logic [DATA_W-1:0] mem_addr;
		logic [DATA_W-1:0] mem_wdata;
		logic wb_valid;
		logic [REG_AW-1:0] wb_reg;
		logic [DATA_W-1:0] wb_data;
		logic redirect;
		logic [DATA_W-1:0] redirect_pc;
		logic halt;
		logic err;
	} exp_t;

	logic clk;
	logic rst_n;
	logic instr_valid;
	logic [INSTR_W-1:0] instr;
	logic [DATA_W-1:0] instr_pc;
	logic [DATA_W-1:0] mem_rdata;
	logic mem_en;
	logic mem_we;
	logic [DATA_W-1:0] mem_addr;
	logic [DATA_W-1:0] mem_wdata;
	logic wb_valid;
	logic [REG_AW-1:0] wb_reg;
	logic [DATA_W-1:0] wb_data;
	logic redirect;
	logic [DATA_W-1:0] redirect_pc;
	logic halt;
	logic err;

	logic [DATA_W-1:0] mem [256];
	logic [DATA_W-1:0] ref_mem [256];
	logic [DATA_W-1:0] ref_regs [REG_N];
	logic halted_m;
	logic [DATA_W-1:0] pc_cnt;
	exp_t d_exp;
	exp_t e_exp;
	exp_t w_exp;
	logic [INSTR_W-1:0] directed [$];

	core_slice_top u_dut (.*);

	// Memory and halt use execute-stage expectations and the rest result-stage ones.
	bind core_slice_top core_slice_checker u_checker (
		.clk(clk), .rst_n(rst_n), .mem_en(mem_en), .mem_we(mem_we),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata), .wb_valid(wb_valid),
		.wb_reg(wb_reg), .wb_data(wb_data), .redirect(redirect),
		.redirect_pc(redirect_pc), .halt(halt), .err(err),
		.exp_mem_en(tb_core_slice.e_exp.mem_en), .exp_mem_we(tb_core_slice.e_exp.mem_we),
		.exp_mem_addr(tb_core_slice.e_exp.mem_addr),
		.exp_mem_wdata(tb_core_slice.e_exp.mem_wdata),
		.exp_wb_valid(tb_core_slice.w_exp.wb_valid), .exp_wb_reg(tb_core_slice.w_exp.wb_reg),
		.exp_wb_data(tb_core_slice.w_exp.wb_data), .exp_redirect(tb_core_slice.w_exp.redirect),
		.exp_redirect_pc(tb_core_slice.w_exp.redirect_pc),
		.exp_halt(tb_core_slice.e_exp.halt), .exp_err(tb_core_slice.w_exp.err)
	);

	// Data memory answers within the execute cycle.
	assign mem_rdata = mem[mem_addr[7:0]];

	always @(posedge clk) begin
		if (mem_en && mem_we) begin
			mem[mem_addr[7:0]] <= mem_wdata;
		end
	end

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [DATA_W-1:0] fill_word(input int i);
		return DATA_W'(i * 40503) ^ {8'h5A, 8'(i)};
	endfunction

	function automatic logic [INSTR_W-1:0] enc_ri(input opcode_e op, input logic [2:0] rs,
			input logic [2:0] rt, input logic [4:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [INSTR_W-1:0] enc_r(input opcode_e op, input logic [2:0] rs,
			input logic [2:0] rt, input logic [2:0] rd, input logic [1:0] func);
		return {op, rs, rt, rd, func};
	endfunction

	function automatic logic [INSTR_W-1:0] enc_i8(input opcode_e op, input logic [2:0] rs,
			input logic [7:0] imm);
		return {op, rs, imm};
	endfunction

	function automatic logic [INSTR_W-1:0] enc_j(input opcode_e op, input logic [10:0] imm);
		return {op, imm};
	endfunction

	// Random words with HALT and reserved function bits removed.
	function automatic logic [INSTR_W-1:0] legalize(input logic [INSTR_W-1:0] w);
		logic [INSTR_W-1:0] v;
		v = w;
		if (v[15:11] == OP_HALT) begin
			v[15:11] = OP_NOP;
		end
		if (v[15:11] == OP_BTR || v[15:11] >= OP_SEQ) begin
			v[1:0] = 2'b00;
		end
		return v;
	endfunction

	// Function code 0..3 is add, B minus A, xor, A and not B.
	function automatic logic [DATA_W-1:0] arith_res(input logic [1:0] f,
			input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
		case (f)
			2'd0: return a + b;
			2'd1: return b - a;
			2'd2: return a ^ b;
			default: return a & ~b;
		endcase
	endfunction

	function automatic logic [DATA_W-1:0] shift_res(input logic [1:0] f,
			input logic [DATA_W-1:0] a, input logic [3:0] s);
		case (f)
			2'd0: return (a << s) | (a >> (5'd16 - s));
			2'd1: return a << s;
			2'd2: return (a >> s) | (a << (5'd16 - s));
			default: return a >> s;
		endcase
	endfunction

	// Bit 0 shifts in first and ends up at the top.
	function automatic logic [DATA_W-1:0] bit_rev(input logic [DATA_W-1:0] a);
		logic [DATA_W-1:0] r;
		r = '0;
		for (int i = 0; i < DATA_W; i++) begin
			r = {r[DATA_W-2:0], a[i]};
		end
		return r;
	endfunction

	// Runs one instruction on the reference model in program order.
	task automatic predict(input logic v, input logic [INSTR_W-1:0] w,
			input logic [DATA_W-1:0] pc);
		opcode_e op;
		logic [REG_AW-1:0] rs;
		logic [REG_AW-1:0] rt;
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		logic [DATA_W-1:0] i5s;
		logic [DATA_W-1:0] i8s;
		logic [DATA_W-1:0] res;
		logic [DATA_W:0] sum;
		d_exp = '0;
		d_exp.halt = halted_m;
		if (!v || halted_m) begin
			return;
		end
		op = opcode_e'(w[15:11]);
		rs = w[10:8];
		rt = w[7:5];
		a = ref_regs[rs];
		b = ref_regs[rt];
		i5s = {{11{w[4]}}, w[4:0]};
		i8s = {{8{w[7]}}, w[7:0]};
		sum = {1'b0, a} + {1'b0, b};
		res = '0;
		d_exp.wb_valid = 1'b1;
		d_exp.wb_reg = rt;
		case (op)
			OP_HALT: begin
				halted_m = 1'b1;
				d_exp.wb_valid = 1'b0;
			end
			OP_ADDI, OP_SUBI: res = arith_res(w[12:11], a, i5s);
			OP_XORI, OP_ANDNI: res = arith_res(w[12:11], a, {11'b0, w[4:0]});
			OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI: res = shift_res(w[12:11], a, w[3:0]);
			OP_ALU_ARITH: begin
				d_exp.wb_reg = w[4:2];
				res = arith_res(w[1:0], a, b);
			end
			OP_ALU_SHIFT: begin
				d_exp.wb_reg = w[4:2];
				res = shift_res(w[1:0], a, b[3:0]);
			end
			OP_SEQ, OP_SLT, OP_SLE, OP_SCO, OP_BTR: begin
				d_exp.wb_reg = w[4:2];
				case (op)
					OP_SEQ: res = DATA_W'(a == b);
					OP_SLT: res = DATA_W'($signed(a) < $signed(b));
					OP_SLE: res = DATA_W'($signed(a) <= $signed(b));
					OP_SCO: res = DATA_W'(sum[DATA_W]);
					default: res = bit_rev(a);
				endcase
				// Nonzero function bits make the encoding undefined.
				if (w[1:0] != 2'b00) begin
					d_exp.wb_valid = 1'b0;
					d_exp.err = 1'b1;
				end
			end
			OP_LBI, OP_SLBI: begin
				d_exp.wb_reg = rs;
				res = (op == OP_LBI) ? i8s : {a[7:0], w[7:0]};
			end
			OP_ST, OP_LD, OP_STU: begin
				d_exp.mem_en = 1'b1;
				d_exp.mem_addr = a + i5s;
				res = d_exp.mem_addr;
				if (op == OP_LD) begin
					res = ref_mem[d_exp.mem_addr[7:0]];
				end else begin
					d_exp.mem_we = 1'b1;
					d_exp.mem_wdata = b;
					ref_mem[d_exp.mem_addr[7:0]] = b;
					d_exp.wb_valid = (op == OP_STU);
					d_exp.wb_reg = rs;
				end
			end
			OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: begin
				d_exp.wb_valid = 1'b0;
				d_exp.redirect_pc = pc + 16'd2 + i8s;
				case (op)
					OP_BEQZ: d_exp.redirect = (a == '0);
					OP_BNEZ: d_exp.redirect = (a != '0);
					OP_BLTZ: d_exp.redirect = a[DATA_W-1];
					default: d_exp.redirect = !a[DATA_W-1];
				endcase
			end
			OP_J, OP_JAL, OP_JR, OP_JALR: begin
				d_exp.redirect = 1'b1;
				if (op == OP_J || op == OP_JAL) begin
					d_exp.redirect_pc = pc + 16'd2 + {{5{w[10]}}, w[10:0]};
				end else begin
					d_exp.redirect_pc = a + i8s;
				end
				d_exp.wb_valid = (op == OP_JAL || op == OP_JALR);
				d_exp.wb_reg = 3'd7;
				res = pc + 16'd2;
			end
			default: d_exp.wb_valid = 1'b0;
		endcase
		d_exp.wb_data = res;
		if (d_exp.wb_valid) begin
			ref_regs[d_exp.wb_reg] = res;
		end
		d_exp.halt = halted_m;
	endtask

	task automatic drive_cycle(input logic v, input logic [INSTR_W-1:0] w);
		@(negedge clk);
		w_exp = e_exp;
		e_exp = d_exp;
		instr_valid = v;
		instr = w;
		instr_pc = pc_cnt;
		predict(v, w, pc_cnt);
		pc_cnt = pc_cnt + 16'd2;
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		d_exp = '0;
		e_exp = '0;
		w_exp = '0;
		halted_m = 1'b0;
		pc_cnt = 16'h0200;
		for (int i = 0; i < REG_N; i++) begin
			ref_regs[i] = '0;
		end
		repeat (RST_CYCLES) @(negedge clk);
		rst_n = 1'b1;
	endtask

	task automatic build_directed();
		directed.push_back(enc_i8(OP_LBI, 3'd1, 8'h35));
		directed.push_back(enc_i8(OP_LBI, 3'd2, 8'hFD));
		directed.push_back(enc_i8(OP_SLBI, 3'd1, 8'hA7));
		directed.push_back(enc_ri(OP_ADDI, 3'd1, 3'd3, 5'h1C));
		directed.push_back(enc_ri(OP_SUBI, 3'd3, 3'd4, 5'd7));
		directed.push_back(enc_ri(OP_XORI, 3'd1, 3'd5, 5'h1F));
		directed.push_back(enc_ri(OP_ANDNI, 3'd1, 3'd6, 5'h0F));
		directed.push_back(enc_ri(OP_ROLI, 3'd1, 3'd7, 5'd4));
		directed.push_back(enc_ri(OP_SLLI, 3'd1, 3'd7, 5'd3));
		directed.push_back(enc_ri(OP_RORI, 3'd1, 3'd0, 5'd5));
		directed.push_back(enc_ri(OP_SRLI, 3'd2, 3'd0, 5'd9));
		for (int f = 0; f < 4; f++) begin
			directed.push_back(enc_r(OP_ALU_ARITH, 3'd1, 3'd2, 3'(f + 3), 2'(f)));
			directed.push_back(enc_r(OP_ALU_SHIFT, 3'd1, 3'd5, 3'(f + 4), 2'(f)));
		end
		directed.push_back(enc_r(OP_SEQ, 3'd1, 3'd1, 3'd4, 2'd0));
		directed.push_back(enc_r(OP_SLT, 3'd1, 3'd2, 3'd5, 2'd0));
		directed.push_back(enc_r(OP_SLE, 3'd2, 3'd1, 3'd6, 2'd0));
		directed.push_back(enc_r(OP_SCO, 3'd2, 3'd2, 3'd7, 2'd0));
		directed.push_back(enc_r(OP_BTR, 3'd1, 3'd0, 3'd3, 2'd0));
		// Store, load back, store with base update.
		directed.push_back(enc_ri(OP_ST, 3'd0, 3'd1, 5'd4));
		directed.push_back(enc_ri(OP_LD, 3'd0, 3'd6, 5'd4));
		directed.push_back(enc_ri(OP_STU, 3'd2, 3'd3, 5'd2));
		directed.push_back(enc_ri(OP_LD, 3'd2, 3'd4, 5'd0));
		directed.push_back(enc_i8(OP_LBI, 3'd3, 8'h00));
		directed.push_back(enc_i8(OP_BEQZ, 3'd3, 8'h10));
		directed.push_back(enc_i8(OP_BNEZ, 3'd3, 8'h10));
		directed.push_back(enc_i8(OP_LBI, 3'd2, 8'h80));
		directed.push_back(enc_i8(OP_BLTZ, 3'd2, 8'hF0));
		directed.push_back(enc_i8(OP_BGEZ, 3'd2, 8'h08));
		directed.push_back(enc_i8(OP_BGEZ, 3'd1, 8'h08));
		directed.push_back(enc_j(OP_J, 11'h040));
		directed.push_back(enc_j(OP_JAL, 11'h7F0));
		directed.push_back(enc_i8(OP_JR, 3'd1, 8'h10));
		directed.push_back(enc_i8(OP_JALR, 3'd7, 8'hFE));
		directed.push_back(enc_j(OP_NOP, 11'd0));
		directed.push_back(enc_j(OP_SIIC, 11'd0));
		directed.push_back(enc_j(OP_RTI, 11'd0));
		// Undefined encodings, then a reader of the registers they name.
		directed.push_back(enc_r(OP_SEQ, 3'd1, 3'd2, 3'd3, 2'd1));
		directed.push_back(enc_r(OP_BTR, 3'd1, 3'd0, 3'd4, 2'd3));
		directed.push_back(enc_r(OP_ALU_ARITH, 3'd3, 3'd4, 3'd5, 2'd0));
	endtask

	task automatic watchdog(input int n_instr);
		#((n_instr + 40 + 2 * RST_CYCLES) * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d clock cycles",
			n_instr + 40 + 2 * RST_CYCLES);
		$display("Finished with errors");
		$fatal(1, "Watchdog expired");
	endtask

	initial begin
		wait (u_dut.u_checker.fail_count != 0);
		$display("FAILED at %0t ns: a checker assertion did not hold", $time);
		$display("Finished with errors");
		$fatal(1, "Stopped at the first error");
	end

	initial begin
		void'($urandom(71));
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		instr_pc = '0;
		for (int i = 0; i < 256; i++) begin
			mem[i] = fill_word(i);
			ref_mem[i] = fill_word(i);
		end
		build_directed();
		fork
			watchdog(directed.size() + N_RAND + N_TAIL);
		join_none
		apply_reset();
		foreach (directed[i]) begin
			drive_cycle(1'b1, directed[i]);
		end
		repeat (N_RAND) drive_cycle(1'b1, legalize(INSTR_W'($urandom())));
		// Everything after HALT is ignored.
		drive_cycle(1'b1, enc_j(OP_HALT, 11'd0));
		drive_cycle(1'b1, enc_i8(OP_LBI, 3'd3, 8'h55));
		drive_cycle(1'b1, enc_ri(OP_ST, 3'd0, 3'd1, 5'd0));
		drive_cycle(1'b1, enc_r(OP_SEQ, 3'd1, 3'd2, 3'd3, 2'd3));
		repeat (3) drive_cycle(1'b0, '0);
		apply_reset();
		repeat (3) drive_cycle(1'b1, legalize(INSTR_W'($urandom())));
		repeat (4) drive_cycle(1'b0, '0);
		if (u_dut.u_checker.fail_count == 0) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			$display("Finished with errors");
			$fatal(1, "Checker reported a mismatch");
		end
	end

endmodule

// File: src.f
verilog/isa_pkg.sv
verilog/ctrl_pkg.sv
verilog/ctrl_if.sv
verilog/exec_if.sv
verilog/instr_decode.sv
verilog/alu_execute.sv
verilog/result_stage.sv
verilog/core_slice_top.sv
bench/core_slice_checker.sv
bench/tb_core_slice.sv
